/* build.f */
+incdir+.
periph_bus_pkg.sv
ems_pkg.sv
io_bus_if.sv
io_decoder.sv
ems_mapper.sv
io_readback.sv
periph_top.sv
periph_chk.sv
periph_scoreboard.sv
tb_periph.sv

/* ems_mapper.sv */
// --------------------------------------
// Four EMS window registers. Writes land on
// each clock edge while the strobe is held,
// hit check and readback are combinational
// --------------------------------------
`timescale 1ns/1ps
`include "periph_macros.svh"

module ems_mapper (
    input  logic                       clock,
    input  logic                       reset,
    io_bus_if.target                   bus,
    input  periph_bus_pkg::io_select_t sel_i,
    input  ems_pkg::ems_frame_t        frame_i,
    output periph_bus_pkg::io_data_t   rdata_o,
    output logic                       hit_o,
    output ems_pkg::ems_index_t        window_o,
    output ems_pkg::ems_page_t         page_o
);
    import periph_bus_pkg::*;
    import ems_pkg::*;

    ems_entry_t entry_q [4];
    ems_wdata_u wdata;
    ems_index_t reg_index;
    ems_index_t mem_index;
    logic [3:0] frame_top;
    logic       reg_write;
    logic       frame_match;

    assign wdata     = bus.wdata;
    assign reg_index = bus.addr[1:0];
    assign reg_write = sel_i.ems & bus.wr;

    // FFh turns the window off, 00h-7Fh maps a page,
    // 80h-FEh is ignored
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                entry_q[i] <= '0;
            end
        end else if (reg_write) begin
            if (wdata.raw == `PERIPH_EMS_DISABLE_CODE) begin
                entry_q[reg_index].enable <= 1'b0;
            end else if (!wdata.fields.flag) begin
                entry_q[reg_index].enable <= 1'b1;
                entry_q[reg_index].page   <= wdata.fields.page;
            end
        end
    end

    // Frame base from the board setting
    always_comb begin
        case (frame_i)
            2'b00:   frame_top = `PERIPH_EMS_FRAME_A;
            2'b01:   frame_top = `PERIPH_EMS_FRAME_C;
            default: frame_top = `PERIPH_EMS_FRAME_D;
        endcase
    end

    // Bits 15-14 pick the 16 KB window inside the frame
    assign mem_index   = bus.addr[15:14];
    assign frame_match = (bus.addr[19:16] == frame_top);
    assign hit_o       = frame_match & entry_q[mem_index].enable;

    // Window and page are only meaningful on a hit
    assign window_o = hit_o ? mem_index : '0;
    assign page_o   = hit_o ? entry_q[mem_index].page : '0;

    // Disabled registers read back as the idle byte
    always_comb begin
        if (entry_q[reg_index].enable) begin
            rdata_o = {1'b0, entry_q[reg_index].page};
        end else begin
            rdata_o = `PERIPH_IDLE_READ;
        end
    end

endmodule

/* ems_pkg.sv */
// --------------------------------------
// EMS mapping types. Four 16 KB windows in
// one 64 KB frame, 128 logical pages
// --------------------------------------
package ems_pkg;

    // Logical page number
    typedef logic [6:0] ems_page_t;

    // One mapping register
    typedef struct packed {
        logic      enable;
        ems_page_t page;
    } ems_entry_t;

    // Field view of a byte written to a mapping register
    typedef struct packed {
        logic      flag;
        ems_page_t page;
    } ems_wdata_fields_t;

    // Written byte, checked whole against the disable code
    // and split into flag and page for a map write
    typedef union packed {
        logic [7:0]        raw;
        ems_wdata_fields_t fields;
    } ems_wdata_u;

    // Window number inside the frame
    typedef logic [1:0] ems_index_t;

    // Frame choice, 00 A000, 01 C000, others D000
    typedef logic [1:0] ems_frame_t;

endpackage

/* io_bus_if.sv */
// --------------------------------------
// Qualified I/O cycle. rd and wr are high
// only while aen is low and the strobe is
// asserted
// --------------------------------------
`timescale 1ns/1ps

interface io_bus_if;
    import periph_bus_pkg::*;

    io_addr_t addr;
    io_data_t wdata;
    logic     rd;
    logic     wr;

    // Top level drives the cycle
    modport host (
        output addr,
        output wdata,
        output rd,
        output wr
    );

    // Decoder and register blocks only observe it
    modport target (
        input addr,
        input wdata,
        input rd,
        input wr
    );

endinterface

/* io_decoder.sv */
// --------------------------------------
// Combinational port decode. Upper address
// bits 15-10 are not checked for the slots,
// as on the original XT board
// --------------------------------------
`timescale 1ns/1ps
`include "periph_macros.svh"

module io_decoder (
    io_bus_if.target                   bus,
    input  logic                       ems_enabled_i,
    output periph_bus_pkg::io_select_t sel_o
);
    import periph_bus_pkg::*;

    slot_sel_t slots_n;
    logic      ems_port;
    logic      lpt_port;

    // Legacy chipset slots live in 000h-0FFh, 32 ports each
    always_comb begin
        slots_n = '1;
        if (bus.addr[9:8] == 2'b00) begin
            slots_n[bus.addr[7:5]] = 1'b0;
        end
    end

    // EMS registers only exist when the board has EMS turned on
    always_comb begin
        ems_port = 1'b0;
        if (ems_enabled_i) begin
            if ({bus.addr[15:2], 2'b00} == `PERIPH_EMS_PORT_BASE) begin
                ems_port = 1'b1;
            end
        end
    end

    // Whole 8-port LPT block maps onto the single data latch
    always_comb begin
        lpt_port = 1'b0;
        if ({bus.addr[15:3], 3'b000} == `PERIPH_LPT_PORT_BASE) begin
            lpt_port = 1'b1;
        end
    end

    assign sel_o.slots = slots_n;
    assign sel_o.ems   = ems_port;
    assign sel_o.lpt   = lpt_port;

endmodule

/* io_readback.sv */
// --------------------------------------
// LPT data latch and CPU read mux. Chipset
// slots return their own data off chip, so
// only EMS and LPT reads are driven here
// --------------------------------------
`timescale 1ns/1ps
`include "periph_macros.svh"

module io_readback (
    input  logic                       clock,
    input  logic                       reset,
    io_bus_if.target                   bus,
    input  periph_bus_pkg::io_select_t sel_i,
    input  periph_bus_pkg::io_data_t   ems_rdata_i,
    output periph_bus_pkg::io_data_t   data_o,
    output logic                       data_drive_o
);
    import periph_bus_pkg::*;

    io_data_t lpt_q;
    logic     lpt_write;
    logic     ems_read;
    logic     lpt_read;

    assign lpt_write = sel_i.lpt & bus.wr;
    assign ems_read  = sel_i.ems & bus.rd;
    assign lpt_read  = sel_i.lpt & bus.rd;

    // Parallel port output latch, idles high like a floating port
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_q <= `PERIPH_IDLE_READ;
        end else if (lpt_write) begin
            lpt_q <= bus.wdata;
        end
    end

    // EMS first, then LPT, otherwise leave the bus to other chips
    always_comb begin
        if (ems_read) begin
            data_o       = ems_rdata_i;
            data_drive_o = 1'b1;
        end else if (lpt_read) begin
            data_o       = lpt_q;
            data_drive_o = 1'b1;
        end else begin
            data_o       = '0;
            data_drive_o = 1'b0;
        end
    end

endmodule

/* periph_bus_pkg.sv */
// --------------------------------------
// CPU I/O bus types. Addresses are the full
// 20-bit bus, only the low 16 bits matter
// for port decode
// --------------------------------------
package periph_bus_pkg;

    // Full 8088 address bus
    typedef logic [19:0] io_addr_t;

    // One data byte
    typedef logic [7:0] io_data_t;

    // Active-low select per 32-port block at 000h-0FFh
    // Bit 0 DMA, 1 PIC, 2 PIT, 3 PPI, 4 DMA page, 5-7 spare
    typedef logic [7:0] slot_sel_t;

    // Decoder result handed to the register blocks
    typedef struct packed {
        slot_sel_t slots;
        logic      ems;
        logic      lpt;
    } io_select_t;

endpackage

/* periph_chk.sv */
// --------------------------------------
// Bound to periph_top. Tracks EMS register
// writes itself to know which windows may
// legally report a hit
// --------------------------------------
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_chk (
    input logic        clock,
    input logic        reset,
    input logic [19:0] address_i,
    input logic        io_read_n_i,
    input logic        io_write_n_i,
    input logic        address_enable_n_i,
    input logic        ems_enabled_i,
    input logic        data_drive_o,
    input logic        dma_cs_n_o,
    input logic        pic_cs_n_o,
    input logic        pit_cs_n_o,
    input logic        ppi_cs_n_o,
    input logic        dma_page_cs_n_o,
    input logic        ems_hit_o,
    input logic [1:0]  ems_window_o
);
    logic [3:0] window_written;
    logic [4:0] cs_low;
    logic       ems_port_write;

    assign cs_low = ~{dma_page_cs_n_o, ppi_cs_n_o, pit_cs_n_o, pic_cs_n_o, dma_cs_n_o};
    assign ems_port_write = ~address_enable_n_i & ~io_write_n_i & ems_enabled_i
        & ({address_i[15:2], 2'b00} == `PERIPH_EMS_PORT_BASE);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            window_written <= '0;
        end else if (ems_port_write) begin
            window_written[address_i[1:0]] <= 1'b1;
        end
    end

    one_slot_selected: assert property (
        @(posedge clock) disable iff (reset) $countones(cs_low) <= 1
    ) else $error("more than one chipset select is low");

    drive_only_on_read: assert property (
        @(posedge clock) disable iff (reset) data_drive_o |-> !io_read_n_i
    ) else $error("read data driven without a read strobe");

    hit_needs_written_window: assert property (
        @(posedge clock) disable iff (reset) ems_hit_o |-> window_written[ems_window_o]
    ) else $error("EMS hit on a window never written since reset");

endmodule

/* periph_macros.svh */
// --------------------------------------
// Fixed PC/XT map constants. Port bases are
// 16-bit I/O addresses, frame tops are
// address bits 19-16 of a 64 KB EMS frame
// --------------------------------------
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// EMS mapping registers, four ports at 260h-263h
`define PERIPH_EMS_PORT_BASE    16'h0260

// Parallel port data latch, decoded over 378h-37Fh
`define PERIPH_LPT_PORT_BASE    16'h0378

// Page frame tops selectable by the frame input
`define PERIPH_EMS_FRAME_A      4'hA
`define PERIPH_EMS_FRAME_C      4'hC
`define PERIPH_EMS_FRAME_D      4'hD

// Written to an EMS register to switch its window off
`define PERIPH_EMS_DISABLE_CODE 8'hFF

// Read value of a disabled window, also the LPT latch after reset
`define PERIPH_IDLE_READ        8'hFF

`endif

/* periph_scoreboard.sv */
// --------------------------------------
// Compares DUT outputs at the falling edge
// of each strobe cycle. Names are up to 16
// characters, packed into 128 bits
// --------------------------------------
`timescale 1ns/1ps

module periph_scoreboard (
    input  logic         clock,
    input  logic         check_i,
    input  logic [1:0]   op_i,
    input  logic [127:0] name_i,
    input  logic [7:0]   exp_data_i,
    input  logic         exp_flag_i,
    input  logic [1:0]   exp_window_i,
    input  logic [7:0]   data_i,
    input  logic         drive_i,
    input  logic [4:0]   cs_n_i,
    input  logic         hit_i,
    input  logic [1:0]   window_i,
    input  logic [6:0]   page_i,
    output int           error_count_o
);
    // Operation codes shared with the testbench table
    localparam logic [1:0] OP_WRITE  = 2'd0;
    localparam logic [1:0] OP_READ   = 2'd1;
    localparam logic [1:0] OP_PROBE  = 2'd2;
    localparam logic [1:0] OP_DECODE = 2'd3;

    initial error_count_o = 0;

    task automatic compare(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAIL %0s %0s expected %0h actual %0h", name_i, what, expected, actual);
            error_count_o = error_count_o + 1;
        end
    endtask

    always @(negedge clock) begin
        if (check_i) begin
            case (op_i)
                OP_WRITE: compare("drive", 0, drive_i);
                OP_READ: begin
                    compare("data", exp_data_i, data_i);
                    compare("drive", exp_flag_i, drive_i);
                end
                OP_PROBE: begin
                    compare("hit", exp_flag_i, hit_i);
                    if (exp_flag_i) begin
                        compare("window", exp_window_i, window_i);
                        compare("page", exp_data_i[6:0], page_i);
                    end
                end
                OP_DECODE: compare("selects", exp_data_i[4:0], cs_n_i);
            endcase
        end
    end

endmodule

/* periph_top.sv */
// --------------------------------------
// XT peripheral I/O block. Strobes and aen
// are active low, selects go to external
// chips which drive their own read data
// --------------------------------------
`timescale 1ns/1ps

module periph_top (
    input  logic                     clock,
    input  logic                     reset,
    input  periph_bus_pkg::io_addr_t address_i,
    input  periph_bus_pkg::io_data_t data_i,
    input  logic                     io_read_n_i,
    input  logic                     io_write_n_i,
    input  logic                     address_enable_n_i,
    input  logic                     ems_enabled_i,
    input  ems_pkg::ems_frame_t      ems_frame_i,
    output periph_bus_pkg::io_data_t data_o,
    output logic                     data_drive_o,
    output logic                     dma_cs_n_o,
    output logic                     pic_cs_n_o,
    output logic                     pit_cs_n_o,
    output logic                     ppi_cs_n_o,
    output logic                     dma_page_cs_n_o,
    output logic                     ems_hit_o,
    output ems_pkg::ems_index_t      ems_window_o,
    output ems_pkg::ems_page_t       ems_page_o
);
    import periph_bus_pkg::*;

    io_bus_if   bus ();
    io_select_t sel;
    io_data_t   ems_rdata;
    logic       cycle_valid;

    // CPU owns the bus while aen is low, DMA cycles are ignored
    assign cycle_valid = ~address_enable_n_i;

    assign bus.addr  = address_i;
    assign bus.wdata = data_i;
    assign bus.rd    = cycle_valid & ~io_read_n_i;
    assign bus.wr    = cycle_valid & ~io_write_n_i;

    io_decoder i_decoder (
        .bus           (bus),
        .ems_enabled_i (ems_enabled_i),
        .sel_o         (sel)
    );

    ems_mapper i_ems_mapper (
        .clock    (clock),
        .reset    (reset),
        .bus      (bus),
        .sel_i    (sel),
        .frame_i  (ems_frame_i),
        .rdata_o  (ems_rdata),
        .hit_o    (ems_hit_o),
        .window_o (ems_window_o),
        .page_o   (ems_page_o)
    );

    io_readback i_readback (
        .clock        (clock),
        .reset        (reset),
        .bus          (bus),
        .sel_i        (sel),
        .ems_rdata_i  (ems_rdata),
        .data_o       (data_o),
        .data_drive_o (data_drive_o)
    );

    // Slot selects only during CPU cycles
    assign dma_cs_n_o      = sel.slots[0] | ~cycle_valid;
    assign pic_cs_n_o      = sel.slots[1] | ~cycle_valid;
    assign pit_cs_n_o      = sel.slots[2] | ~cycle_valid;
    assign ppi_cs_n_o      = sel.slots[3] | ~cycle_valid;
    assign dma_page_cs_n_o = sel.slots[4] | ~cycle_valid;

endmodule

/* run_sim.sh */
#!/bin/bash
# Build and run the testbench with Verilator, pass is decided from the log

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_periph -o sim_periph
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_periph > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulator exited with an error"
    exit 1
fi

cat sim.log
if grep -q "^Simulation completed successfully$" sim.log; then
    exit 0
fi
exit 1

/* tb_periph.sv */
// --------------------------------------
// Table driven test of periph_top. One
// entry per two clocks, strobes low in the
// first and high in the second
// --------------------------------------
`timescale 1ns/1ps
`include "periph_macros.svh"

module tb_periph;
    localparam logic [1:0] OP_WRITE  = 2'd0;
    localparam logic [1:0] OP_READ   = 2'd1;
    localparam logic [1:0] OP_PROBE  = 2'd2;
    localparam logic [1:0] OP_DECODE = 2'd3;

    typedef struct packed {
        logic [127:0] name;
        logic [1:0]   op;
        logic         aen_n;
        logic [19:0]  addr;
        logic [7:0]   data;
        logic         ems_en;
        logic [1:0]   frame;
        logic [7:0]   exp_data;
        logic         exp_flag;
        logic [1:0]   exp_window;
    } entry_t;

    entry_t       table_q[$];
    logic         clock;
    logic         reset;
    logic [19:0]  address;
    logic [7:0]   data_in;
    logic         io_read_n;
    logic         io_write_n;
    logic         aen_n;
    logic         ems_enabled;
    logic [1:0]   ems_frame;
    logic [7:0]   data_out;
    logic         data_drive;
    logic         dma_cs_n;
    logic         pic_cs_n;
    logic         pit_cs_n;
    logic         ppi_cs_n;
    logic         dma_page_cs_n;
    logic         ems_hit;
    logic [1:0]   ems_window;
    logic [6:0]   ems_page;
    logic         check;
    entry_t       cur;
    int           errors;
    int           cycle_count;
    int           cycle_limit;

    periph_top i_dut (
        .clock              (clock),
        .reset              (reset),
        .address_i          (address),
        .data_i             (data_in),
        .io_read_n_i        (io_read_n),
        .io_write_n_i       (io_write_n),
        .address_enable_n_i (aen_n),
        .ems_enabled_i      (ems_enabled),
        .ems_frame_i        (ems_frame),
        .data_o             (data_out),
        .data_drive_o       (data_drive),
        .dma_cs_n_o         (dma_cs_n),
        .pic_cs_n_o         (pic_cs_n),
        .pit_cs_n_o         (pit_cs_n),
        .ppi_cs_n_o         (ppi_cs_n),
        .dma_page_cs_n_o    (dma_page_cs_n),
        .ems_hit_o          (ems_hit),
        .ems_window_o       (ems_window),
        .ems_page_o         (ems_page)
    );

    periph_scoreboard i_scoreboard (
        .clock         (clock),
        .check_i       (check),
        .op_i          (cur.op),
        .name_i        (cur.name),
        .exp_data_i    (cur.exp_data),
        .exp_flag_i    (cur.exp_flag),
        .exp_window_i  (cur.exp_window),
        .data_i        (data_out),
        .drive_i       (data_drive),
        .cs_n_i        ({dma_page_cs_n, ppi_cs_n, pit_cs_n, pic_cs_n, dma_cs_n}),
        .hit_i         (ems_hit),
        .window_i      (ems_window),
        .page_i        (ems_page),
        .error_count_o (errors)
    );

    bind periph_top periph_chk i_chk (.*);

    task automatic add(input logic [127:0] name, input logic [1:0] op, input logic a_n,
                       input logic [19:0] addr, input logic [7:0] data, input logic en,
                       input logic [1:0] frame, input logic [7:0] exp_data,
                       input logic exp_flag, input logic [1:0] exp_window);
        entry_t e;
        e = '{name, op, a_n, addr, data, en, frame, exp_data, exp_flag, exp_window};
        table_q.push_back(e);
    endtask

    task automatic build_table();
        // Selects as {dma_page, ppi, pit, pic, dma}, active low
        add("dec_dma", OP_DECODE, 0, 20'h000, 0, 1, 0, 8'h1E, 0, 0);
        add("dec_pic", OP_DECODE, 0, 20'h020, 0, 1, 0, 8'h1D, 0, 0);
        add("dec_pit", OP_DECODE, 0, 20'h040, 0, 1, 0, 8'h1B, 0, 0);
        add("dec_ppi", OP_DECODE, 0, 20'h060, 0, 1, 0, 8'h17, 0, 0);
        add("dec_page", OP_DECODE, 0, 20'h080, 0, 1, 0, 8'h0F, 0, 0);
        add("dec_100", OP_DECODE, 0, 20'h100, 0, 1, 0, 8'h1F, 0, 0);
        add("dec_aen_high", OP_DECODE, 1, 20'h000, 0, 1, 0, 8'h1F, 0, 0);
        add("dec_0a0", OP_DECODE, 0, 20'h0A0, 0, 1, 0, 8'h1F, 0, 0);
        add("dec_0ff", OP_DECODE, 0, 20'h0FF, 0, 1, 0, 8'h1F, 0, 0);
        add("lpt_reset", OP_READ, 0, `PERIPH_LPT_PORT_BASE, 0, 1, 0, 8'hFF, 1, 0);
        // EMS map writes and readback
        add("ems_wr0", OP_WRITE, 0, 20'h260, 8'h05, 1, 0, 0, 0, 0);
        add("ems_wr1", OP_WRITE, 0, 20'h261, 8'h12, 1, 0, 0, 0, 0);
        add("ems_wr2", OP_WRITE, 0, 20'h262, 8'h7F, 1, 0, 0, 0, 0);
        add("ems_wr3", OP_WRITE, 0, 20'h263, 8'h00, 1, 0, 0, 0, 0);
        add("ems_rd0", OP_READ, 0, 20'h260, 0, 1, 0, 8'h05, 1, 0);
        add("ems_rd1", OP_READ, 0, 20'h261, 0, 1, 0, 8'h12, 1, 0);
        add("ems_rd2", OP_READ, 0, 20'h262, 0, 1, 0, 8'h7F, 1, 0);
        add("ems_rd3", OP_READ, 0, 20'h263, 0, 1, 0, 8'h00, 1, 0);
        add("ems_off1", OP_WRITE, 0, 20'h261, `PERIPH_EMS_DISABLE_CODE, 1, 0, 0, 0, 0);
        add("ems_rd_off1", OP_READ, 0, 20'h261, 0, 1, 0, `PERIPH_IDLE_READ, 1, 0);
        // 80h-FEh must leave the register alone
        add("ems_wr_80", OP_WRITE, 0, 20'h260, 8'h80, 1, 0, 0, 0, 0);
        add("ems_rd_80", OP_READ, 0, 20'h260, 0, 1, 0, 8'h05, 1, 0);
        add("ems_wr_fe", OP_WRITE, 0, 20'h260, 8'hFE, 1, 0, 0, 0, 0);
        add("ems_rd_fe", OP_READ, 0, 20'h260, 0, 1, 0, 8'h05, 1, 0);
        add("ems_dis_wr", OP_WRITE, 0, 20'h262, 8'h33, 0, 0, 0, 0, 0);
        add("ems_dis_rd", OP_READ, 0, 20'h262, 0, 0, 0, 8'h00, 0, 0);
        add("ems_en_rd", OP_READ, 0, 20'h262, 0, 1, 0, 8'h7F, 1, 0);
        // Window hits
        add("ems_remap1", OP_WRITE, 0, 20'h261, 8'h12, 1, 0, 0, 0, 0);
        add("hit_c4000_a", OP_PROBE, 0, 20'hC4000, 0, 1, 0, 0, 0, 0);
        add("hit_a4000_a", OP_PROBE, 0, 20'hA4000, 0, 1, 0, 8'h12, 1, 1);
        add("hit_c8000_c", OP_PROBE, 0, 20'hC8000, 0, 1, 1, 8'h7F, 1, 2);
        add("ems_unmap1", OP_WRITE, 0, 20'h261, 8'hFF, 1, 0, 0, 0, 0);
        add("hit_off_a", OP_PROBE, 0, 20'hA4000, 0, 1, 0, 0, 0, 0);
        // LPT latch and an unmapped port
        add("lpt_wr", OP_WRITE, 0, `PERIPH_LPT_PORT_BASE, 8'h5A, 1, 0, 0, 0, 0);
        add("lpt_rd_37b", OP_READ, 0, 20'h37B, 0, 1, 0, 8'h5A, 1, 0);
        add("rd_unmapped", OP_READ, 0, 20'h300, 0, 1, 0, 8'h00, 0, 0);
    endtask

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Run limit from the table length, set once the table exists
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        address     = '0;
        data_in     = '0;
        io_read_n   = 1'b1;
        io_write_n  = 1'b1;
        aen_n       = 1'b1;
        ems_enabled = 1'b0;
        ems_frame   = '0;
        check       = 1'b0;
        cur         = '0;
        cycle_count = 0;
        cycle_limit = 0;
        build_table();
        cycle_limit = 16 + 2 * table_q.size() + 20;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        foreach (table_q[i]) begin
            @(posedge clock);
            cur         <= table_q[i];
            address     <= table_q[i].addr;
            data_in     <= table_q[i].data;
            aen_n       <= table_q[i].aen_n;
            ems_enabled <= table_q[i].ems_en;
            ems_frame   <= table_q[i].frame;
            io_write_n  <= (table_q[i].op != OP_WRITE);
            io_read_n   <= (table_q[i].op != OP_READ);
            check       <= 1'b1;
            @(posedge clock);
            io_write_n  <= 1'b1;
            io_read_n   <= 1'b1;
            check       <= 1'b0;
        end
        repeat (2) @(posedge clock);
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
